// ==== nco_pkg.sv ====
package nco_pkg;

    localparam int LUT_LATENCY = 3; // theta to table output
    localparam int MIX_LATENCY = 5; // sample_valid to out_valid

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        logic signed [15:0] sine;
        logic signed [15:0] cosine;
    } sincos_t;

    typedef struct packed {
        logic signed [15:0] i;
        logic signed [15:0] q;
    } iq_t;

    typedef enum logic [0:0] {
        CFG_FREQ  = 1'b0,
        CFG_PHASE = 1'b1
    } config_sel_t;

    typedef struct packed {
        logic        clear;    // restart accumulator at 0
        logic [24:0] reserved;
        logic [5:0]  offset;   // added to table phase
    } phase_cfg_t;

    // same 32 bits, read by config_select
    typedef union packed {
        logic [31:0] freq;
        phase_cfg_t  phase;
    } config_word_u;

endpackage

// ==== mixer_control.sv ====
module mixer_control #(
    parameter int PHASE_BITS = 32
) (
    input  logic                   clock,
    input  logic                   clock_sreset,
    input  logic                   config_write,
    input  nco_pkg::config_sel_t   config_select,
    input  nco_pkg::config_word_u  config_data,
    input  logic                   sample_valid,
    output logic [PHASE_BITS-1:0]  tuning_word,
    output logic [5:0]             phase_offset,
    output logic                   phase_clear,
    output logic                   out_valid
);

    localparam int VALID_DEPTH = nco_pkg::MIX_LATENCY;

    logic                   freq_write;
    logic                   phase_write;
    logic [VALID_DEPTH-1:0] valid_pipe; // one bit per sample in flight

    assign freq_write  = config_write && (config_select == nco_pkg::CFG_FREQ);
    assign phase_write = config_write && (config_select == nco_pkg::CFG_PHASE);

    // tuning word keeps the top bits of the freq view
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            tuning_word <= '0;
        end
        else if (freq_write) begin
            tuning_word <= config_data.freq[31 -: PHASE_BITS];
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            phase_offset <= '0;
        end
        else if (phase_write) begin
            phase_offset <= config_data.phase.offset;
        end
    end

    // one cycle pulse after the write
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            phase_clear <= 1'b0;
        end
        else begin
            phase_clear <= phase_write && config_data.phase.clear;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            valid_pipe <= '0;
        end
        else begin
            valid_pipe <= {valid_pipe[VALID_DEPTH-2:0], sample_valid};
        end
    end

    assign out_valid = valid_pipe[VALID_DEPTH-1];

endmodule

// ==== phase_accumulator.sv ====
module phase_accumulator #(
    parameter int PHASE_BITS = 32
) (
    input  logic                  clock,
    input  logic                  clock_sreset,
    input  logic                  sample_valid,
    input  logic [PHASE_BITS-1:0] tuning_word,
    input  logic [5:0]            phase_offset,
    input  logic                  phase_clear,
    output logic [5:0]            theta
);

    logic [PHASE_BITS-1:0] accumulator;
    logic [PHASE_BITS-1:0] phase_base;

    // a pending clear wins over the stored phase
    assign phase_base = phase_clear ? '0 : accumulator;

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            accumulator <= '0;
            theta       <= '0;
        end
        else begin
            if (sample_valid) begin
                theta       <= phase_base[PHASE_BITS-1 -: 6] + phase_offset; // wraps mod 64
                accumulator <= phase_base + tuning_word;
            end
            else if (phase_clear) begin
                accumulator <= '0;
            end
        end
    end

endmodule

// ==== sine_cosine_16lut.sv ====
module sine_cosine_16lut (
    input  logic             clock,
    input  logic             clock_sreset,
    input  logic [5:0]       theta,
    output nco_pkg::sincos_t sincos
);

    logic [5:0] theta_reg;
    logic [3:0] sine_address;
    logic [3:0] cosine_address;
    logic [1:0] quadrant;      // theta[5:4] aligned with the addresses

    // first quarter of a sine at odd multiples of pi/64
    function automatic logic signed [15:0] quarter_wave(input logic [3:0] address);
        logic signed [31:0] word;
        case (address)
            4'h0:    word = 32'sh0647d97c;
            4'h1:    word = 32'sh12c8106e;
            4'h2:    word = 32'sh1f19f97a;
            4'h3:    word = 32'sh2b1f34eb;
            4'h4:    word = 32'sh36ba2013;
            4'h5:    word = 32'sh41ce1e64;
            4'h6:    word = 32'sh4c3fdff2;
            4'h7:    word = 32'sh55f5a4d1;
            4'h8:    word = 32'sh5ed77c88;
            4'h9:    word = 32'sh66cf811f;
            4'ha:    word = 32'sh6dca0d13;
            4'hb:    word = 32'sh73b5ebd0;
            4'hc:    word = 32'sh78848412;
            4'hd:    word = 32'sh7c29fbed;
            4'he:    word = 32'sh7e9d55fb;
            default: word = 32'sh7fd8878c;
        endcase
        return 16'(word >>> 16);
    endfunction

    always_ff @(posedge clock) begin
        theta_reg      <= theta;
        sine_address   <= theta_reg[3:0] ^ {4{theta_reg[4]}};  // mirror in odd quadrants
        cosine_address <= theta_reg[3:0] ^ {4{~theta_reg[4]}}; // mirror in even quadrants
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            quadrant <= '0;
            sincos   <= '0;
        end
        else begin
            quadrant      <= theta_reg[5:4];
            sincos.sine   <= quadrant[1] ? -quarter_wave(sine_address)
                                         : quarter_wave(sine_address);
            sincos.cosine <= (^quadrant) ? -quarter_wave(cosine_address)
                                         : quarter_wave(cosine_address);
        end
    end

endmodule

// ==== quadrature_mixer.sv ====
module quadrature_mixer (
    input  logic             clock,
    input  logic             clock_sreset,
    input  nco_pkg::sample_t sample_in,
    input  nco_pkg::sincos_t sincos,
    output nco_pkg::iq_t     out_iq
);

    // one cycle for the accumulator plus the table pipeline
    localparam int DELAY = nco_pkg::LUT_LATENCY + 1;

    nco_pkg::sample_t   sample_pipe [DELAY];
    logic signed [31:0] i_product;
    logic signed [31:0] q_product;

    always_ff @(posedge clock) begin
        sample_pipe[0] <= sample_in;
        for (int n = 1; n < DELAY; n++) begin
            sample_pipe[n] <= sample_pipe[n-1];
        end
    end

    // table peak is below 2^15 so the products never reach -2^31
    assign i_product = sample_pipe[DELAY-1] * sincos.cosine;
    assign q_product = -(sample_pipe[DELAY-1] * sincos.sine);

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            out_iq <= '0;
        end
        else begin
            out_iq.i <= i_product[30:15]; // >>> 15 then keep 16 bits
            out_iq.q <= q_product[30:15];
        end
    end

endmodule

// ==== nco_downconverter.sv ====
module nco_downconverter #(
    parameter int PHASE_BITS = 32
) (
    input  logic                  clock,
    input  logic                  clock_sreset,
    input  logic                  sample_valid,
    input  nco_pkg::sample_t      sample_in,
    input  logic                  config_write,
    input  nco_pkg::config_sel_t  config_select,
    input  nco_pkg::config_word_u config_data,
    output logic                  out_valid,
    output nco_pkg::iq_t          out_iq
);

    logic [PHASE_BITS-1:0] tuning_word;
    logic [5:0]            phase_offset;
    logic                  phase_clear;
    logic [5:0]            theta;
    nco_pkg::sincos_t      sincos;

    mixer_control #(
        .PHASE_BITS (PHASE_BITS)
    ) i_mixer_control (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .config_write  (config_write),
        .config_select (config_select),
        .config_data   (config_data),
        .sample_valid  (sample_valid),
        .tuning_word   (tuning_word),
        .phase_offset  (phase_offset),
        .phase_clear   (phase_clear),
        .out_valid     (out_valid)
    );

    phase_accumulator #(
        .PHASE_BITS (PHASE_BITS)
    ) i_phase_accumulator (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .sample_valid (sample_valid),
        .tuning_word  (tuning_word),
        .phase_offset (phase_offset),
        .phase_clear  (phase_clear),
        .theta        (theta)
    );

    sine_cosine_16lut i_sine_cosine_16lut (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .theta        (theta),
        .sincos       (sincos)
    );

    quadrature_mixer i_quadrature_mixer (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .sample_in    (sample_in),
        .sincos       (sincos),
        .out_iq       (out_iq)
    );

endmodule

// ==== tb_nco_downconverter.sv ====
module tb_nco_downconverter;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PHASE_BITS     = 32;
    localparam int CLOCK_PERIOD   = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int ZERO_SAMPLES   = 8;
    localparam int SWEEP_SAMPLES  = 3 * 64;
    localparam int OFFSET_SAMPLES = 26;
    localparam int GAPPED_SAMPLES = 40;
    localparam int RETUNE_SAMPLES = 24;
    localparam int SAMPLE_TOTAL   = ZERO_SAMPLES + SWEEP_SAMPLES + OFFSET_SAMPLES
                                  + GAPPED_SAMPLES + RETUNE_SAMPLES;
    localparam int TIMEOUT_MARGIN = 2000; // ns for reset and drain

    logic                  clock = 1'b0;
    logic                  clock_sreset;
    logic                  sample_valid;
    nco_pkg::sample_t      sample_in;
    logic                  config_write;
    nco_pkg::config_sel_t  config_select;
    nco_pkg::config_word_u config_data;
    logic                  out_valid;
    nco_pkg::iq_t          out_iq;

    integer seed = 67;

    // round(2^31 sin((2k+1)pi/64)) for k = 0..15
    logic signed [31:0] sine_table [16] = '{
        32'sh0647d97c, 32'sh12c8106e, 32'sh1f19f97a, 32'sh2b1f34eb,
        32'sh36ba2013, 32'sh41ce1e64, 32'sh4c3fdff2, 32'sh55f5a4d1,
        32'sh5ed77c88, 32'sh66cf811f, 32'sh6dca0d13, 32'sh73b5ebd0,
        32'sh78848412, 32'sh7c29fbed, 32'sh7e9d55fb, 32'sh7fd8878c
    };

    logic [PHASE_BITS-1:0]            model_acc    = '0;
    logic [PHASE_BITS-1:0]            model_tuning = '0;
    logic [5:0]                       model_offset = '0;
    logic                             model_clear  = 1'b0; // clear pending for next edge
    nco_pkg::iq_t                     expected_q [$];
    logic [nco_pkg::MIX_LATENCY-1:0]  valid_history = '0;
    int                               reset_edges = 0;

    nco_downconverter #(
        .PHASE_BITS (PHASE_BITS)
    ) i_nco_downconverter (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .sample_valid  (sample_valid),
        .sample_in     (sample_in),
        .config_write  (config_write),
        .config_select (config_select),
        .config_data   (config_data),
        .out_valid     (out_valid),
        .out_iq        (out_iq)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    initial begin
        #(SAMPLE_TOTAL * 10 * CLOCK_PERIOD + TIMEOUT_MARGIN);
        $display("timeout: the tests did not finish in time");
        stop_run();
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_iq(input string name, input nco_pkg::iq_t expected,
                            input nco_pkg::iq_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected i=%0d q=%0d, got i=%0d q=%0d", $time,
                     name, expected.i, expected.q, actual.i, actual.q);
            stop_run();
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic nco_pkg::iq_t expected_iq(input nco_pkg::sample_t sample,
                                                 input logic [5:0] theta);
        logic [3:0]         sine_address;
        logic [3:0]         cosine_address;
        logic signed [15:0] sine;
        logic signed [15:0] cosine;
        logic signed [31:0] i_full;
        logic signed [31:0] q_full;
        nco_pkg::iq_t       result;
        sine_address   = theta[4] ? ~theta[3:0] : theta[3:0];
        cosine_address = theta[4] ? theta[3:0] : ~theta[3:0];
        sine   = 16'(sine_table[sine_address] >>> 16);
        cosine = 16'(sine_table[cosine_address] >>> 16);
        if (theta[5]) begin
            sine = -sine;
        end
        if (theta[5] ^ theta[4]) begin
            cosine = -cosine;
        end
        i_full   = sample * cosine;
        q_full   = -(sample * sine);
        result.i = 16'(i_full >>> 15);
        result.q = 16'(q_full >>> 15);
        return result;
    endfunction

    // one DUT edge of the reference model
    task automatic model_cycle(input logic valid, input nco_pkg::sample_t sample,
                               input logic write, input nco_pkg::config_sel_t sel,
                               input nco_pkg::config_word_u data);
        logic [PHASE_BITS-1:0] base;
        logic [5:0]            theta;
        base = model_clear ? '0 : model_acc;
        if (valid) begin
            theta = base[PHASE_BITS-1 -: 6] + model_offset; // mod 64
            expected_q.push_back(expected_iq(sample, theta));
        end
        model_acc   = valid ? base + model_tuning : base;
        model_clear = write && sel == nco_pkg::CFG_PHASE && data.phase.clear;
        if (write && sel == nco_pkg::CFG_FREQ) begin
            model_tuning = data.freq[31 -: PHASE_BITS];
        end
        if (write && sel == nco_pkg::CFG_PHASE) begin
            model_offset = data.phase.offset;
        end
    endtask

    task automatic drive_cycle(input logic valid, input nco_pkg::sample_t sample,
                               input logic write, input nco_pkg::config_sel_t sel,
                               input nco_pkg::config_word_u data);
        @(posedge clock);
        sample_valid  <= valid;
        sample_in     <= sample;
        config_write  <= write;
        config_select <= sel;
        config_data   <= data;
        model_cycle(valid, sample, write, sel, data);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle(1'b0, '0, 1'b0, nco_pkg::CFG_FREQ, '0);
    endtask

    task automatic send_sample(input nco_pkg::sample_t sample);
        drive_cycle(1'b1, sample, 1'b0, nco_pkg::CFG_FREQ, '0);
    endtask

    task automatic write_config(input nco_pkg::config_sel_t sel,
                                input nco_pkg::config_word_u data);
        drive_cycle(1'b0, '0, 1'b1, sel, data);
    endtask

    function automatic nco_pkg::sample_t random_sample();
        return nco_pkg::sample_t'($random(seed));
    endfunction

    function automatic nco_pkg::config_word_u freq_word(input logic [31:0] tuning);
        nco_pkg::config_word_u word;
        word.freq = tuning;
        return word;
    endfunction

    function automatic nco_pkg::config_word_u phase_word(input logic clear,
                                                         input logic [5:0] offset);
        nco_pkg::config_word_u word;
        word.phase.clear    = clear;
        word.phase.reserved = '0;
        word.phase.offset   = offset;
        return word;
    endfunction

    // wait for every sample in flight to come out
    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 4 * nco_pkg::MIX_LATENCY) begin
            idle(1);
            @(negedge clock); // queue is settled between edges
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d expected results never came out of the DUT", expected_q.size());
            stop_run();
        end
    endtask

    always @(posedge clock) begin
        if (clock_sreset) begin
            if (reset_edges > 0) begin
                check_valid("out_valid", 1'b0, out_valid);
            end
            reset_edges++;
            valid_history = '0;
        end
        else begin
            check_valid("out_valid", valid_history[nco_pkg::MIX_LATENCY-1], out_valid);
            valid_history = {valid_history[nco_pkg::MIX_LATENCY-2:0], sample_valid};
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid rose at %0t ns with no result expected", $time);
                    stop_run();
                end
                else begin
                    check_iq("out_iq", expected_q.pop_front(), out_iq);
                end
            end
        end
    end

    task automatic reset_quiet();
        repeat (RESET_CYCLES) @(posedge clock);
        clock_sreset <= 1'b0;
        idle(12); // out_valid held low with nothing sent
    endtask

    task automatic zero_frequency();
        write_config(nco_pkg::CFG_FREQ, freq_word(32'h0));
        write_config(nco_pkg::CFG_PHASE, phase_word(1'b0, 6'd0));
        repeat (ZERO_SAMPLES) send_sample(random_sample());
        drain();
    endtask

    task automatic phase_sweep(input int k);
        write_config(nco_pkg::CFG_FREQ, freq_word(32'(k) << 26));
        repeat (64) send_sample(random_sample());
        drain();
    endtask

    task automatic offset_and_clear();
        write_config(nco_pkg::CFG_FREQ, freq_word(32'h0c00_1234));
        repeat (6) send_sample(random_sample());
        write_config(nco_pkg::CFG_PHASE, phase_word(1'b1, 6'd21));
        repeat (10) send_sample(random_sample());
        write_config(nco_pkg::CFG_PHASE, phase_word(1'b1, 6'd50));
        idle(3); // clear lands between samples
        repeat (10) send_sample(random_sample());
        drain();
    endtask

    task automatic gapped_input();
        int gap;
        write_config(nco_pkg::CFG_FREQ, freq_word(32'h0580_0000));
        repeat (GAPPED_SAMPLES) begin
            gap = $unsigned($random(seed)) % 7;
            idle(gap);
            send_sample(random_sample());
        end
        drain();
    endtask

    task automatic retune_midstream();
        write_config(nco_pkg::CFG_FREQ, freq_word(32'h1c00_0000));
        repeat (8) send_sample(random_sample());
        write_config(nco_pkg::CFG_FREQ, freq_word(32'h0b00_0000));
        repeat (8) send_sample(random_sample());
        // write in the same cycle as a sample
        drive_cycle(1'b1, random_sample(), 1'b1, nco_pkg::CFG_FREQ, freq_word(32'hf400_0000));
        repeat (7) send_sample(random_sample());
        drain();
    endtask

    initial begin
        clock_sreset  = 1'b1;
        sample_valid  = 1'b0;
        sample_in     = '0;
        config_write  = 1'b0;
        config_select = nco_pkg::CFG_FREQ;
        config_data   = '0;
        reset_quiet();
        zero_frequency();
        phase_sweep(1);
        phase_sweep(5);
        phase_sweep(63);
        offset_and_clear();
        gapped_input();
        retune_midstream();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
nco_pkg.sv
mixer_control.sv
phase_accumulator.sv
sine_cosine_16lut.sv
quadrature_mixer.sv
nco_downconverter.sv
tb_nco_downconverter.sv
